/* tb/cpu_patterns.txt */
# T name | P word_addr instr | E byte_addr data (store order) | H halt_pc | R run
# Values are hex
T alu_chain
P 00 B135
P 01 B20C
P 02 BF40
P 03 0312
P 04 1431
P 05 2543
P 06 3651
P 07 476D
P 08 5874
P 09 698C
P 0A 93F0
P 0B 94F1
P 0C 95F2
P 0D 96F3
P 0E 97F4
P 0F 98F5
P 10 99F6
P 11 F000
E 0040 0041
E 0042 000C
E 0044 004D
E 0046 0005
E 0048 A000
E 004A FA00
E 004C A00F
H 0024
R
T load_use
P 00 B15A
P 01 A112
P 02 BF20
P 03 91F0
P 04 B203
P 05 83F0
P 06 0432
P 07 94F1
P 08 85F1
P 09 95FF
P 0A F000
E 0020 125A
E 0022 125D
E 001E 125D
H 0016
R
T byte_merge
P 00 A1AB
P 01 B1CD
P 02 9100
P 03 A134
P 04 9101
P 05 B2FF
P 06 A280
P 07 B201
P 08 9202
P 09 F000
E 0000 ABCD
E 0002 34CD
E 0004 8001
H 0014
R
T branches
P 00 B101
P 01 B202
P 02 B3FF
P 03 A37F
P 04 BF60
P 05 1411
P 06 C201
P 07 92F0
P 08 C801
P 09 92F1
P 0A C001
P 0B 92F2
P 0C CC01
P 0D 92F3
P 0E 1412
P 0F C601
P 10 92F4
P 11 CA01
P 12 92F5
P 13 C401
P 14 92F6
P 15 C801
P 16 92F7
P 17 1421
P 18 C001
P 19 92F8
P 1A C401
P 1B 92F9
P 1C C201
P 1D 92FA
P 1E C601
P 1F 92FB
P 20 CA01
P 21 92FC
P 22 0431
P 23 CC01
P 24 92FD
P 25 CE01
P 26 92FE
P 27 92FF
P 28 F000
E 0064 0002
E 0066 0002
E 006C 0002
E 006E 0002
E 0054 0002
E 0056 0002
E 0058 0002
E 005E 0002
H 0052
R
T br_pcs
P 00 E100
P 01 9100
P 02 B20A
P 03 DE20
P 04 9101
P 05 E300
P 06 9302
P 07 D220
P 08 9303
P 09 F000
E 0000 0002
E 0004 000C
E 0006 000C
H 0014
R
T halt
P 00 B177
P 01 CE01
P 02 F000
P 03 9100
P 04 F000
P 05 9101
E 0000 0077
H 000A
R

/* all.f */
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/dmem_if.sv
hw/alu.sv
hw/reg_file.sv
hw/hazard_unit.sv
hw/sram_16.sv
hw/cpu_core.sv
hw/cpu_top.sv
tb/tb_clk_gen.sv
tb/tb_cpu.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_cpu -o tb_cpu_sim \
	&& out=$(./obj_dir/tb_cpu_sim) \
	&& echo "$out" \
	&& echo "$out" | grep -qx "STATUS: PASS" \
	&& exit 0 \
	|| exit 1

/* tb/tb_cpu.sv */
`timescale 1ns/100ps

module tb_cpu;

	localparam int RUN_LIMIT  = 2000;
	localparam int HOLD_CHECK = 20;

	logic        clk, por_n, core_run, arst_n;
	logic        prog_we;
	logic [7:0]  prog_addr;
	logic [15:0] prog_data;
	logic        hlt, st_valid;
	logic [15:0] pc_out, st_addr, st_data;

	logic [7:0]  prog_a[$];
	logic [15:0] prog_d[$];
	logic [15:0] exp_a[$];
	logic [15:0] exp_d[$];
	logic [15:0] got_a[$];
	logic [15:0] got_d[$];
	logic [15:0] exp_halt;
	logic [8*32-1:0] test_name;

	int check_errors = 0;
	int tests_run = 0;
	int tests_bad = 0;
	bit timed_out = 1'b0;
	bit file_err = 1'b0;

	tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(4)) clk_gen_i (.clk(clk), .por_n(por_n));

	assign arst_n = por_n && core_run;

	cpu_top cpu_top_i (
		.clk(clk),
		.arst_n(arst_n),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.hlt(hlt),
		.pc_out(pc_out),
		.st_valid(st_valid),
		.st_addr(st_addr),
		.st_data(st_data)
	);

	task automatic check_value(input string what, input logic [15:0] got,
			input logic [15:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %0s got %h expected %h", $time, what, got, exp);
			check_errors++;
		end
	endtask

	// ------------------------------
	// One program: load, run, compare
	// ------------------------------
	task automatic run_program();
		int cyc;
		int errs_before;
		errs_before = check_errors;
		@(negedge clk);
		core_run = 1'b0;
		foreach (prog_a[i]) begin
			prog_we = 1'b1;
			prog_addr = prog_a[i];
			prog_data = prog_d[i];
			@(negedge clk);
		end
		prog_we = 1'b0;
		@(negedge clk);
		got_a.delete();
		got_d.delete();
		core_run = 1'b1;
		cyc = 0;
		while (!hlt && cyc < RUN_LIMIT) begin
			@(negedge clk);
			cyc++;
			if (st_valid) begin
				got_a.push_back(st_addr);
				got_d.push_back(st_data);
			end
		end
		if (!hlt) begin
			$display("Timeout: test %0s did not halt within %0d cycles", test_name, RUN_LIMIT);
			timed_out = 1'b1;
			return;
		end
		check_value("halt pc", pc_out, exp_halt);
		// Core must stay frozen with no further stores
		repeat (HOLD_CHECK) begin
			@(negedge clk);
			check_value("pc after halt", pc_out, exp_halt);
			check_value("hlt level", {15'd0, hlt}, 16'd1);
			if (st_valid) begin
				$display("Store seen after halt at %0t, address %h", $time, st_addr);
				check_errors++;
			end
		end
		check_value("store count", 16'(got_a.size()), 16'(exp_a.size()));
		foreach (exp_a[i]) begin
			if (i < got_a.size()) begin
				check_value($sformatf("store %0d address", i), got_a[i], exp_a[i]);
				check_value($sformatf("store %0d data", i), got_d[i], exp_d[i]);
			end
		end
		tests_run++;
		if (check_errors != errs_before) begin
			tests_bad++;
		end
		$display("test %0s: %0d stores, %0d errors", test_name, got_a.size(),
			check_errors - errs_before);
	endtask

	initial begin
		int fd;
		int code;
		int cyc;
		string line;
		logic [8*16-1:0] tag;
		logic [15:0] v1, v2;

		core_run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		exp_halt = '0;
		test_name = "none";

		cyc = 0;
		while (!por_n && cyc < 100) begin
			@(negedge clk);
			cyc++;
		end
		if (!por_n) begin
			$display("Power-on reset never released");
			timed_out = 1'b1;
		end

		fd = $fopen("tb/cpu_patterns.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the pattern file tb/cpu_patterns.txt");
			file_err = 1'b1;
		end else begin
			while (!$feof(fd) && !timed_out) begin
				code = $fgets(line, fd);
				if (code != 0) begin
					tag = '0;
					code = $sscanf(line, "%s %h %h", tag, v1, v2);
					if (tag == "T") begin
						code = $sscanf(line, "%s %s", tag, test_name);
						prog_a.delete();
						prog_d.delete();
						exp_a.delete();
						exp_d.delete();
					end else if (tag == "P") begin
						prog_a.push_back(v1[7:0]);
						prog_d.push_back(v2);
					end else if (tag == "E") begin
						exp_a.push_back(v1);
						exp_d.push_back(v2);
					end else if (tag == "H") begin
						exp_halt = v1;
					end else if (tag == "R") begin
						run_program();
					end
				end
			end
			$fclose(fd);
		end

		$display("tests run %0d, tests with errors %0d, failed checks %0d", tests_run,
			tests_bad, check_errors);
		if (check_errors == 0 && !timed_out && !file_err && tests_run > 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen #(
	parameter int PERIOD_NS  = 40,
	parameter int RST_CYCLES = 4
) (
	output logic clk,
	output logic por_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Power-on reset, released after a few rising edges
	initial begin
		por_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		por_n = 1'b1;
	end

endmodule

/* hw/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top #(
	parameter int CPU_DATA_W  = 16,
	parameter int IMEM_ADDR_W = 8,
	parameter int DMEM_ADDR_W = 7
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   prog_we,
	input  logic [IMEM_ADDR_W-1:0] prog_addr,
	input  logic [CPU_DATA_W-1:0]  prog_data,
	output logic                   hlt,
	output logic [CPU_DATA_W-1:0]  pc_out,
	output logic                   st_valid,
	output logic [CPU_DATA_W-1:0]  st_addr,
	output logic [CPU_DATA_W-1:0]  st_data
);

	logic [CPU_DATA_W-1:0] imem_addr;
	logic [CPU_DATA_W-1:0] imem_rdata;

	dmem_if #(.CPU_DATA_W(CPU_DATA_W)) dmem_bus ();

	cpu_core #(.CPU_DATA_W(CPU_DATA_W)) cpu_core_i (
		.clk(clk),
		.arst_n(arst_n),
		.imem_addr(imem_addr),
		.imem_data(imem_rdata),
		.dmem(dmem_bus.core),
		.hlt(hlt),
		.pc_out(pc_out)
	);

	// Program loading only while the core sits in reset
	sram_16 #(
		.ADDR_W(IMEM_ADDR_W),
		.CPU_DATA_W(CPU_DATA_W)
	) imem_i (
		.clk(clk),
		.we(prog_we && !arst_n),
		.waddr(prog_addr),
		.wdata(prog_data),
		.raddr(imem_addr[IMEM_ADDR_W:1]),
		.rdata(imem_rdata)
	);

	// Byte addresses from the core, word addresses into the array
	sram_16 #(
		.ADDR_W(DMEM_ADDR_W),
		.CPU_DATA_W(CPU_DATA_W)
	) dmem_i (
		.clk(clk),
		.we(dmem_bus.en && dmem_bus.wr),
		.waddr(dmem_bus.addr[DMEM_ADDR_W:1]),
		.wdata(dmem_bus.wdata),
		.raddr(dmem_bus.addr[DMEM_ADDR_W:1]),
		.rdata(dmem_bus.rdata)
	);

	// Store trace for the testbench
	assign st_valid = dmem_bus.en && dmem_bus.wr;
	assign st_addr = dmem_bus.addr;
	assign st_data = dmem_bus.wdata;

endmodule

/* hw/cpu_core.sv */
`timescale 1ns/100ps

module cpu_core
	import isa_pkg::*;
	import pipe_pkg::*;
#(
	parameter int CPU_DATA_W = 16
) (
	input  logic                  clk,
	input  logic                  arst_n,
	output logic [CPU_DATA_W-1:0] imem_addr,
	input  instr_u                imem_data,
	dmem_if.core                  dmem,
	output logic                  hlt,
	output logic [CPU_DATA_W-1:0] pc_out
);

	localparam instr_u BUBBLE = BUBBLE_WORD;

	logic [CPU_DATA_W-1:0] pc_q, pc_plus2, br_target;
	logic                  fetch_halted_q, fetch_hold, br_taken, stall;

	instr_u                id_instr;
	op_e                   id_op;
	logic [CPU_DATA_W-1:0] id_pc2, id_rs_data, id_rt_data;
	logic [3:0]            id_rs_sel, id_rt_sel;
	logic                  id_we;

	instr_u                ex_instr;
	op_e                   ex_op;
	logic [CPU_DATA_W-1:0] ex_pc2, ex_rs_data, ex_rt_data;
	logic [3:0]            ex_rs_sel, ex_rt_sel, ex_rd;
	logic                  ex_we, cond_met;
	logic [1:0]            fwd_a, fwd_b;
	logic [CPU_DATA_W-1:0] op_a, op_b, alu_b, alu_result, ex_addr, ex_result;
	logic [2:0]            alu_flags, alu_flag_we, flags_q;

	op_e                   mem_op;
	logic                  mem_we;
	logic [3:0]            mem_sel;
	logic [CPU_DATA_W-1:0] mem_result, mem_wdata, mem_fwd;

	logic                  wb_we, wb_halt, halt_seen, hlt_q;
	logic [3:0]            wb_sel;
	logic [CPU_DATA_W-1:0] wb_data;

	// ------------------------------
	// Fetch
	// ------------------------------
	assign pc_plus2 = pc_q + CPU_DATA_W'(2);
	assign fetch_hold = (id_op == OP_HLT) || fetch_halted_q;
	assign imem_addr = pc_q;
	assign pc_out = pc_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q <= RESET_PC;
			fetch_halted_q <= 1'b0;
		end else begin
			if (br_taken) begin
				pc_q <= br_target;
			end else if (!stall && !fetch_hold) begin
				pc_q <= pc_plus2;
			end
			// A halt flushed by an older branch does not count
			if (id_op == OP_HLT && !br_taken) begin
				fetch_halted_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_instr <= BUBBLE;
		end else if (br_taken || (fetch_hold && !stall)) begin
			id_instr <= BUBBLE;
		end else if (!stall) begin
			id_instr <= imem_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			id_pc2 <= pc_plus2;
		end
	end

	// ------------------------------
	// Decode
	// ------------------------------
	assign id_op = id_instr.r.op;

	// Unused sources stay at R0 so they never stall or forward
	always_comb begin
		id_rs_sel = 4'd0;
		id_rt_sel = 4'd0;
		id_we = 1'b0;
		case (id_op)
			OP_ADD, OP_SUB, OP_XOR, OP_AND: begin
				id_rs_sel = id_instr.r.rs;
				id_rt_sel = id_instr.r.rt;
				id_we = 1'b1;
			end
			OP_SLL, OP_SRA, OP_ROR: begin
				id_rs_sel = id_instr.r.rs;
				id_we = 1'b1;
			end
			OP_LW: begin
				id_rt_sel = id_instr.r.rs;
				id_we = 1'b1;
			end
			OP_SW: begin
				id_rs_sel = id_instr.r.rd;
				id_rt_sel = id_instr.r.rs;
			end
			OP_LHB, OP_LLB: begin
				id_rs_sel = id_instr.r.rd;
				id_we = 1'b1;
			end
			OP_BR:  id_rs_sel = id_instr.r.rs;
			OP_PCS: id_we = 1'b1;
			default: id_we = 1'b0;
		endcase
	end

	reg_file #(.CPU_DATA_W(CPU_DATA_W)) reg_file_i (
		.clk(clk),
		.arst_n(arst_n),
		.rs_sel(id_rs_sel),
		.rt_sel(id_rt_sel),
		.wb_we(wb_we),
		.wb_sel(wb_sel),
		.wb_data(wb_data),
		.rs_data(id_rs_data),
		.rt_data(id_rt_data)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_instr <= BUBBLE;
			ex_we <= 1'b0;
			ex_rs_sel <= 4'd0;
			ex_rt_sel <= 4'd0;
		end else if (br_taken || stall) begin
			ex_instr <= BUBBLE;
			ex_we <= 1'b0;
			ex_rs_sel <= 4'd0;
			ex_rt_sel <= 4'd0;
		end else begin
			ex_instr <= id_instr;
			ex_we <= id_we;
			ex_rs_sel <= id_rs_sel;
			ex_rt_sel <= id_rt_sel;
		end
	end

	always_ff @(posedge clk) begin
		ex_pc2 <= id_pc2;
		ex_rs_data <= id_rs_data;
		ex_rt_data <= id_rt_data;
	end

	// ------------------------------
	// Execute
	// ------------------------------
	assign ex_op = ex_instr.r.op;
	assign ex_rd = ex_instr.r.rd;

	function automatic logic [CPU_DATA_W-1:0] fwd_mux(input logic [1:0] sel,
			input logic [CPU_DATA_W-1:0] reg_val);
		if (sel == FWD_MEM) begin
			return mem_fwd;
		end else if (sel == FWD_WB) begin
			return wb_data;
		end
		return reg_val;
	endfunction

	assign op_a = fwd_mux(fwd_a, ex_rs_data);
	assign op_b = fwd_mux(fwd_b, ex_rt_data);

	// Shift amount comes from the rt field itself
	assign alu_b = (ex_op == OP_SLL || ex_op == OP_SRA || ex_op == OP_ROR) ?
		{{(CPU_DATA_W-4){1'b0}}, ex_instr.r.rt} : op_b;

	// Base plus signed word offset
	assign ex_addr = op_b + {{(CPU_DATA_W-5){ex_instr.r.rt[3]}}, ex_instr.r.rt, 1'b0};

	alu #(.CPU_DATA_W(CPU_DATA_W)) alu_i (
		.a(op_a),
		.b(alu_b),
		.op(ex_op),
		.result(alu_result),
		.flags(alu_flags),
		.flag_we(alu_flag_we)
	);

	always_comb begin
		case (ex_op)
			OP_LW, OP_SW: ex_result = ex_addr;
			OP_LHB:       ex_result = {ex_instr.i.imm8, op_a[7:0]};
			OP_LLB:       ex_result = {op_a[CPU_DATA_W-1:8], ex_instr.i.imm8};
			OP_PCS:       ex_result = ex_pc2;
			default:      ex_result = alu_result;
		endcase
	end

	always_comb begin
		case (ex_instr.b.cond)
			COND_NE: cond_met = !flags_q[FLAG_Z];
			COND_EQ: cond_met = flags_q[FLAG_Z];
			COND_GT: cond_met = !flags_q[FLAG_Z] && !flags_q[FLAG_N];
			COND_LT: cond_met = flags_q[FLAG_N];
			COND_GE: cond_met = flags_q[FLAG_Z] || !flags_q[FLAG_N];
			COND_LE: cond_met = flags_q[FLAG_N] || flags_q[FLAG_Z];
			COND_OV: cond_met = flags_q[FLAG_V];
			default: cond_met = 1'b1;
		endcase
	end

	assign br_taken = (ex_op == OP_B || ex_op == OP_BR) && cond_met;
	assign br_target = (ex_op == OP_BR) ? op_a :
		ex_pc2 + {{(CPU_DATA_W-10){ex_instr.b.imm9[8]}}, ex_instr.b.imm9, 1'b0};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags_q <= 3'b000;
			mem_op <= BUBBLE.r.op;
			mem_we <= 1'b0;
			mem_sel <= 4'd0;
		end else begin
			flags_q <= (flags_q & ~alu_flag_we) | (alu_flags & alu_flag_we);
			mem_op <= ex_op;
			mem_we <= ex_we;
			mem_sel <= ex_rd;
		end
	end

	always_ff @(posedge clk) begin
		mem_result <= ex_result;
		mem_wdata <= op_a;
	end

	// ------------------------------
	// Memory and writeback
	// ------------------------------
	assign dmem.en = (mem_op == OP_LW) || (mem_op == OP_SW);
	assign dmem.wr = (mem_op == OP_SW);
	assign dmem.addr = mem_result;
	assign dmem.wdata = mem_wdata;
	assign mem_fwd = (mem_op == OP_LW) ? dmem.rdata : mem_result;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_we <= 1'b0;
			wb_sel <= 4'd0;
			wb_halt <= 1'b0;
			hlt_q <= 1'b0;
		end else begin
			wb_we <= mem_we;
			wb_sel <= mem_sel;
			wb_halt <= (mem_op == OP_HLT);
			hlt_q <= hlt_q | halt_seen;
		end
	end

	always_ff @(posedge clk) begin
		wb_data <= mem_fwd;
	end

	hazard_unit hazard_unit_i (
		.ex_rs(ex_rs_sel),
		.ex_rt(ex_rt_sel),
		.ex_rd(ex_rd),
		.id_rs(id_rs_sel),
		.id_rt(id_rt_sel),
		.ex_is_load(ex_op == OP_LW),
		.mem_we(mem_we),
		.wb_we(wb_we),
		.mem_sel(mem_sel),
		.wb_sel(wb_sel),
		.wb_is_halt(wb_halt),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.stall(stall),
		.halt_seen(halt_seen)
	);

	assign hlt = hlt_q | halt_seen;

	a_pc_even: assert property (@(posedge clk) disable iff (!arst_n) !pc_out[0]);

	// Stalled consumer picks the load value up from WB, never from MEM
	a_load_use_wb: assert property (@(posedge clk) disable iff (!arst_n)
		stall && (id_rs_sel == ex_rd) |-> ##2 (fwd_a == FWD_WB));

endmodule

/* hw/sram_16.sv */
`timescale 1ns/100ps

module sram_16 #(
	parameter int ADDR_W     = 8,
	parameter int CPU_DATA_W = 16
) (
	input  logic                  clk,
	input  logic                  we,
	input  logic [ADDR_W-1:0]     waddr,
	input  logic [CPU_DATA_W-1:0] wdata,
	input  logic [ADDR_W-1:0]     raddr,
	output logic [CPU_DATA_W-1:0] rdata
);

	logic [CPU_DATA_W-1:0] mem [2**ADDR_W];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Asynchronous read port
	assign rdata = mem[raddr];

endmodule

/* hw/hazard_unit.sv */
`timescale 1ns/100ps

module hazard_unit
	import pipe_pkg::*;
(
	input  logic [3:0] ex_rs,
	input  logic [3:0] ex_rt,
	input  logic [3:0] ex_rd,
	input  logic [3:0] id_rs,
	input  logic [3:0] id_rt,
	input  logic       ex_is_load,
	input  logic       mem_we,
	input  logic       wb_we,
	input  logic [3:0] mem_sel,
	input  logic [3:0] wb_sel,
	input  logic       wb_is_halt,
	output logic [1:0] fwd_a,
	output logic [1:0] fwd_b,
	output logic       stall,
	output logic       halt_seen
);

	// Youngest producer wins, R0 is never forwarded
	function automatic logic [1:0] fwd_sel(input logic [3:0] src);
		if (src == 4'd0) begin
			return FWD_REG;
		end else if (mem_we && mem_sel == src) begin
			return FWD_MEM;
		end else if (wb_we && wb_sel == src) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	assign fwd_a = fwd_sel(ex_rs);
	assign fwd_b = fwd_sel(ex_rt);

	// Load result is not ready until MEM, so hold ID one cycle
	assign stall = ex_is_load && (ex_rd != 4'd0) && ((ex_rd == id_rs) || (ex_rd == id_rt));

	assign halt_seen = wb_is_halt;

endmodule

/* hw/reg_file.sv */
`timescale 1ns/100ps

module reg_file #(
	parameter int CPU_DATA_W = 16
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [3:0]            rs_sel,
	input  logic [3:0]            rt_sel,
	input  logic                  wb_we,
	input  logic [3:0]            wb_sel,
	input  logic [CPU_DATA_W-1:0] wb_data,
	output logic [CPU_DATA_W-1:0] rs_data,
	output logic [CPU_DATA_W-1:0] rt_data
);

	logic [CPU_DATA_W-1:0] regs [16];

	// R0 reads zero, a same-cycle write is seen by the reader
	function automatic logic [CPU_DATA_W-1:0] read_port(input logic [3:0] sel);
		if (sel == 4'd0) begin
			return '0;
		end else if (wb_we && wb_sel == sel) begin
			return wb_data;
		end
		return regs[sel];
	endfunction

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			regs <= '{default: '0};
		end else if (wb_we && wb_sel != 4'd0) begin
			regs[wb_sel] <= wb_data;
		end
	end

	assign rs_data = read_port(rs_sel);
	assign rt_data = read_port(rt_sel);

endmodule

/* hw/alu.sv */
`timescale 1ns/100ps

module alu
	import isa_pkg::*;
#(
	parameter int CPU_DATA_W = 16
) (
	input  logic [CPU_DATA_W-1:0] a,
	input  logic [CPU_DATA_W-1:0] b,
	input  op_e                   op,
	output logic [CPU_DATA_W-1:0] result,
	output logic [2:0]            flags,
	output logic [2:0]            flag_we
);

	localparam int MSB = CPU_DATA_W - 1;

	logic [3:0] shamt;
	logic       ovf;

	assign shamt = b[3:0];

	always_comb begin
		result = '0;
		ovf = 1'b0;
		case (op)
			OP_ADD: begin
				result = a + b;
				ovf = (a[MSB] == b[MSB]) && (result[MSB] != a[MSB]);
			end
			OP_SUB: begin
				result = a - b;
				// Signs differ and the result took the subtrahend's sign
				ovf = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]);
			end
			OP_XOR: result = a ^ b;
			OP_AND: result = a & b;
			OP_SLL: result = a << shamt;
			OP_SRA: result = $signed(a) >>> shamt;
			OP_ROR: result = (shamt == 4'd0) ? a : ((a >> shamt) | (a << (CPU_DATA_W - shamt)));
			default: result = '0;
		endcase
	end

	always_comb begin
		flags = '0;
		flags[FLAG_Z] = (result == '0);
		flags[FLAG_V] = ovf;
		flags[FLAG_N] = result[MSB];
	end

	// Arithmetic sets all three, logic and shifts only Z
	always_comb begin
		flag_we = '0;
		if (op == OP_ADD || op == OP_SUB) begin
			flag_we = '1;
		end else if (!op[3] && op != OP_NOP) begin
			flag_we[FLAG_Z] = 1'b1;
		end
	end

endmodule

/* hw/dmem_if.sv */
`timescale 1ns/100ps

interface dmem_if #(
	parameter int CPU_DATA_W = 16
);

	logic                  en;
	logic                  wr;
	logic [CPU_DATA_W-1:0] addr;
	logic [CPU_DATA_W-1:0] wdata;
	logic [CPU_DATA_W-1:0] rdata;

	// Core side issues the access, memory side answers
	modport core (output en, wr, addr, wdata, input rdata);
	modport mem  (input en, wr, addr, wdata, output rdata);

endinterface

/* hw/pipe_pkg.sv */
package pipe_pkg;

	import isa_pkg::*;

	// Operand source for the EX stage
	localparam logic [1:0] FWD_REG = 2'b00;
	localparam logic [1:0] FWD_WB  = 2'b01;
	localparam logic [1:0] FWD_MEM = 2'b10;

	// First fetch address after reset
	localparam logic [15:0] RESET_PC = 16'h0000;

	// What a flushed or stalled stage carries
	localparam logic [15:0] BUBBLE_WORD = {OP_NOP, 12'h000};

endpackage

/* hw/isa_pkg.sv */
package isa_pkg;

	// Four-bit major opcode, bits 15:12 of every word
	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_XOR = 4'h2,
		OP_AND = 4'h3,
		OP_SLL = 4'h4,
		OP_SRA = 4'h5,
		OP_ROR = 4'h6,
		OP_NOP = 4'h7,
		OP_LW  = 4'h8,
		OP_SW  = 4'h9,
		OP_LHB = 4'hA,
		OP_LLB = 4'hB,
		OP_B   = 4'hC,
		OP_BR  = 4'hD,
		OP_PCS = 4'hE,
		OP_HLT = 4'hF
	} op_e;

	// Branch conditions, tested against the flag register
	typedef enum logic [2:0] {
		COND_NE  = 3'b000,
		COND_EQ  = 3'b001,
		COND_GT  = 3'b010,
		COND_LT  = 3'b011,
		COND_GE  = 3'b100,
		COND_LE  = 3'b101,
		COND_OV  = 3'b110,
		COND_ALW = 3'b111
	} cond_e;

	// Flag register bit positions
	localparam int FLAG_Z = 2;
	localparam int FLAG_V = 1;
	localparam int FLAG_N = 0;

	// Register form
	typedef struct packed {
		op_e        op;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
	} instr_r_t;

	// Immediate form, LHB and LLB
	typedef struct packed {
		op_e        op;
		logic [3:0] rd;
		logic [7:0] imm8;
	} instr_i_t;

	// Branch form
	typedef struct packed {
		op_e        op;
		cond_e      cond;
		logic [8:0] imm9;
	} instr_b_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
		instr_b_t b;
	} instr_u;

endpackage
